//--- hw/cam_pkg.sv
package cam_pkg;

    // CAM geometry
    localparam int CAM_DEPTH       = 8;                   // Number of rows
    localparam int CAM_DATA_WIDTH  = 16;                  // Bits per stored word
    localparam int CAM_ADDR_WIDTH  = $clog2(CAM_DEPTH);   // Row address width

    // Port counts
    localparam int CAM_WRITE_PORTS = 2;                   // Independent write ports
    localparam int CAM_READ_PORTS  = 2;                   // Parallel search ports

    // Stored or searched word
    typedef logic [CAM_DATA_WIDTH-1:0] cam_word_t;

    // Row address on a write port
    typedef logic [CAM_ADDR_WIDTH-1:0] cam_addr_t;

    // One bit per row, used for write selects and match lines
    typedef logic [CAM_DEPTH-1:0] cam_row_mask_t;

endpackage : cam_pkg

//--- hw/cam_write_decoder.sv
`timescale 1ns/1ps

module cam_write_decoder (
    input  logic                                                   clk,
    input  logic                                                   rst_i,
    input  logic          [cam_pkg::CAM_WRITE_PORTS-1:0]           write_en_i,
    input  cam_pkg::cam_addr_t [cam_pkg::CAM_WRITE_PORTS-1:0]      write_addr_i,
    input  cam_pkg::cam_word_t [cam_pkg::CAM_WRITE_PORTS-1:0]      write_data_i,
    output cam_pkg::cam_row_mask_t [cam_pkg::CAM_WRITE_PORTS-1:0]  row_sel_o,
    output cam_pkg::cam_word_t [cam_pkg::CAM_WRITE_PORTS-1:0]      wr_data_o
);

    logic [cam_pkg::CAM_WRITE_PORTS-1:0]                wr_en_q;    // Registered enables
    cam_pkg::cam_addr_t [cam_pkg::CAM_WRITE_PORTS-1:0]  wr_addr_q;  // Registered addresses

    // Control part of the request, cleared by reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_en_q <= '0;                                  // No pending writes out of reset
        end else begin
            wr_en_q <= write_en_i;                          // One cycle request stage
        end
    end

    // Address and data only matter while the enable is set
    always_ff @(posedge clk) begin
        wr_addr_q <= write_addr_i;                          // Held for the decode below
        wr_data_o <= write_data_i;                          // Lines up with row_sel_o
    end

    // Address to one-hot row select per port
    always_comb begin
        for (int p = 0; p < cam_pkg::CAM_WRITE_PORTS; p++) begin
            row_sel_o[p] = '0;                              // Idle port selects no row
            if (wr_en_q[p]) begin
                row_sel_o[p][wr_addr_q[p]] = 1'b1;          // Exactly one row for a live write
            end
        end
    end

    // Storage relies on at most one row per port per cycle
    for (genvar p = 0; p < cam_pkg::CAM_WRITE_PORTS; p++) begin : g_sel_check
        a_row_sel_onehot0 : assert property (
            @(posedge clk) disable iff (rst_i)
            $onehot0(row_sel_o[p])
        ) else $error("row_sel_o[%0d] not one-hot: %h", p, row_sel_o[p]);
    end

endmodule : cam_write_decoder

//--- hw/cam_storage_array.sv
`timescale 1ns/1ps

module cam_storage_array (
    input  logic                                                   clk,
    input  logic                                                   rst_i,
    input  cam_pkg::cam_row_mask_t [cam_pkg::CAM_WRITE_PORTS-1:0]  row_sel_i,
    input  cam_pkg::cam_word_t [cam_pkg::CAM_WRITE_PORTS-1:0]      wr_data_i,
    input  cam_pkg::cam_word_t [cam_pkg::CAM_READ_PORTS-1:0]       search_data_i,
    output cam_pkg::cam_word_t [cam_pkg::CAM_READ_PORTS-1:0][cam_pkg::CAM_DEPTH-1:0]
                                                                   bit_match_o
);

    cam_pkg::cam_word_t [cam_pkg::CAM_DEPTH-1:0] rows_q;   // Stored words, one per row
    logic [cam_pkg::CAM_DEPTH-1:0]               row_we;   // Row write enable
    cam_pkg::cam_word_t [cam_pkg::CAM_DEPTH-1:0] row_wdata; // Word picked for each row

    // Per-row write enable and port priority
    always_comb begin
        for (int r = 0; r < cam_pkg::CAM_DEPTH; r++) begin
            row_we[r]    = 1'b0;
            row_wdata[r] = rows_q[r];                       // Default keeps the old word
            // Ascending scan so the last hit, the highest port, wins
            for (int p = 0; p < cam_pkg::CAM_WRITE_PORTS; p++) begin
                if (row_sel_i[p][r]) begin
                    row_we[r]    = 1'b1;
                    row_wdata[r] = wr_data_i[p];
                end
            end
        end
    end

    // Row registers
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rows_q <= '0;                                   // Empty CAM holds all zeros
        end else begin
            for (int r = 0; r < cam_pkg::CAM_DEPTH; r++) begin
                if (row_we[r]) begin
                    rows_q[r] <= row_wdata[r];              // Only selected rows toggle
                end
            end
        end
    end

    // Bit-wise compare, every search port against every row
    always_comb begin
        for (int p = 0; p < cam_pkg::CAM_READ_PORTS; p++) begin
            for (int r = 0; r < cam_pkg::CAM_DEPTH; r++) begin
                bit_match_o[p][r] = search_data_i[p] ~^ rows_q[r];  // 1 where bits agree
            end
        end
    end

    // Highest-numbered port wins a row that several ports select
    for (genvar r = 0; r < cam_pkg::CAM_DEPTH; r++) begin : g_prio_check
        a_row_prio : assert property (
            @(posedge clk) disable iff (rst_i)
            row_sel_i[cam_pkg::CAM_WRITE_PORTS-1][r]
                |=> (rows_q[r] == $past(wr_data_i[cam_pkg::CAM_WRITE_PORTS-1]))
        ) else $error("row %0d did not take the highest port's word", r);
    end

endmodule : cam_storage_array

//--- hw/cam_match_resolver.sv
`timescale 1ns/1ps

module cam_match_resolver (
    input  logic                                                   clk,
    input  logic                                                   rst_i,
    input  cam_pkg::cam_word_t [cam_pkg::CAM_READ_PORTS-1:0][cam_pkg::CAM_DEPTH-1:0]
                                                                   bit_match_i,
    input  logic          [cam_pkg::CAM_READ_PORTS-1:0]            read_en_i,
    output cam_pkg::cam_row_mask_t [cam_pkg::CAM_READ_PORTS-1:0]   match_line_o
);

    cam_pkg::cam_row_mask_t [cam_pkg::CAM_READ_PORTS-1:0] row_match;  // Unregistered masks

    // All-bits reduction, a row hits only when every bit agrees
    always_comb begin
        for (int p = 0; p < cam_pkg::CAM_READ_PORTS; p++) begin
            for (int r = 0; r < cam_pkg::CAM_DEPTH; r++) begin
                row_match[p][r] = &bit_match_i[p][r];
            end
        end
    end

    // Registered match lines, gated by each port's read enable
    always_ff @(posedge clk) begin
        if (rst_i) begin
            match_line_o <= '0;                             // No matches out of reset
        end else begin
            for (int p = 0; p < cam_pkg::CAM_READ_PORTS; p++) begin
                if (read_en_i[p]) begin
                    match_line_o[p] <= row_match[p];        // Live search result
                end else begin
                    match_line_o[p] <= '0;                  // Disabled port reports nothing
                end
            end
        end
    end

    // A disabled port must show an empty mask in the following cycle
    for (genvar p = 0; p < cam_pkg::CAM_READ_PORTS; p++) begin : g_gate_check
        a_read_gate : assert property (
            @(posedge clk) disable iff (rst_i)
            !read_en_i[p] |=> (match_line_o[p] == '0)
        ) else $error("match_line_o[%0d] nonzero with read disabled: %h",
                      p, match_line_o[p]);
    end

endmodule : cam_match_resolver

//--- hw/cam_top.sv
`timescale 1ns/1ps

module cam_top (
    input  logic                                                   clk,
    input  logic                                                   rst_i,
    input  logic          [cam_pkg::CAM_WRITE_PORTS-1:0]           write_en_i,
    input  cam_pkg::cam_addr_t [cam_pkg::CAM_WRITE_PORTS-1:0]      write_addr_i,
    input  cam_pkg::cam_word_t [cam_pkg::CAM_WRITE_PORTS-1:0]      write_data_i,
    input  logic          [cam_pkg::CAM_READ_PORTS-1:0]            read_en_i,
    input  cam_pkg::cam_word_t [cam_pkg::CAM_READ_PORTS-1:0]       read_data_i,
    output cam_pkg::cam_row_mask_t [cam_pkg::CAM_READ_PORTS-1:0]   match_line_o
);

    cam_pkg::cam_row_mask_t [cam_pkg::CAM_WRITE_PORTS-1:0] row_sel;   // Decoded write rows
    cam_pkg::cam_word_t [cam_pkg::CAM_WRITE_PORTS-1:0]     wr_data;   // Data aligned to row_sel
    cam_pkg::cam_word_t [cam_pkg::CAM_READ_PORTS-1:0][cam_pkg::CAM_DEPTH-1:0]
                                                           bit_match; // Per-bit compare

    // Write request stage
    cam_write_decoder u_decoder (
        .clk          (clk),
        .rst_i        (rst_i),
        .write_en_i   (write_en_i),
        .write_addr_i (write_addr_i),
        .write_data_i (write_data_i),
        .row_sel_o    (row_sel),
        .wr_data_o    (wr_data)
    );

    // Rows and compare array, search words go straight in
    cam_storage_array u_storage (
        .clk           (clk),
        .rst_i         (rst_i),
        .row_sel_i     (row_sel),
        .wr_data_i     (wr_data),
        .search_data_i (read_data_i),
        .bit_match_o   (bit_match)
    );

    // Row reduction, read gating and output register
    cam_match_resolver u_resolver (
        .clk          (clk),
        .rst_i        (rst_i),
        .bit_match_i  (bit_match),
        .read_en_i    (read_en_i),
        .match_line_o (match_line_o)
    );

endmodule : cam_top

//--- bench/cam_tb.sv
`timescale 1ns/1ps

module cam_tb;

    localparam int RESET_CYCLES    = 5;
    localparam int DIRECTED_CYCLES = 20;                // Tests 1 to 5 plus the final flush
    localparam int RANDOM_CYCLES   = 200;
    localparam int MARGIN_CYCLES   = 50;
    localparam int CLK_PERIOD_NS   = 10;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES
                                     + MARGIN_CYCLES;

    logic                                                 clk;
    logic                                                 rst_i;
    logic [cam_pkg::CAM_WRITE_PORTS-1:0]                  write_en_i;
    cam_pkg::cam_addr_t [cam_pkg::CAM_WRITE_PORTS-1:0]    write_addr_i;
    cam_pkg::cam_word_t [cam_pkg::CAM_WRITE_PORTS-1:0]    write_data_i;
    logic [cam_pkg::CAM_READ_PORTS-1:0]                   read_en_i;
    cam_pkg::cam_word_t [cam_pkg::CAM_READ_PORTS-1:0]     read_data_i;
    cam_pkg::cam_row_mask_t [cam_pkg::CAM_READ_PORTS-1:0] match_line_o;

    // Inputs for the next cycle, filled by the tests
    logic [cam_pkg::CAM_WRITE_PORTS-1:0]                  stage_we;
    cam_pkg::cam_addr_t [cam_pkg::CAM_WRITE_PORTS-1:0]    stage_wa;
    cam_pkg::cam_word_t [cam_pkg::CAM_WRITE_PORTS-1:0]    stage_wd;
    logic [cam_pkg::CAM_READ_PORTS-1:0]                   stage_re;
    cam_pkg::cam_word_t [cam_pkg::CAM_READ_PORTS-1:0]     stage_rd;

    cam_pkg::cam_word_t model_rows [cam_pkg::CAM_DEPTH];   // Model row contents
    logic [cam_pkg::CAM_WRITE_PORTS-1:0]                  pend_we;  // Write one edge back
    cam_pkg::cam_addr_t [cam_pkg::CAM_WRITE_PORTS-1:0]    pend_wa;
    cam_pkg::cam_word_t [cam_pkg::CAM_WRITE_PORTS-1:0]    pend_wd;
    cam_pkg::cam_row_mask_t exp_mask [cam_pkg::CAM_READ_PORTS];  // For the last search

    logic [31:0] lfsr;
    int          errors;
    int          checks;

    cam_top u_dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .write_en_i   (write_en_i),
        .write_addr_i (write_addr_i),
        .write_data_i (write_data_i),
        .read_en_i    (read_en_i),
        .read_data_i  (read_data_i),
        .match_line_o (match_line_o)
    );

    always #5 clk = ~clk;                               // 10 ns period

    // Galois LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    task automatic set_write(input int port, input cam_pkg::cam_addr_t addr,
                             input cam_pkg::cam_word_t data);
        stage_we[port] = 1'b1;
        stage_wa[port] = addr;
        stage_wd[port] = data;
    endtask

    task automatic set_search(input int port, input cam_pkg::cam_word_t data);
        stage_re[port] = 1'b1;
        stage_rd[port] = data;
    endtask

    // DUT output after the sampling edge against the model
    task automatic compare_masks();
        for (int p = 0; p < cam_pkg::CAM_READ_PORTS; p++) begin
            checks++;
            assert (match_line_o[p] === exp_mask[p]) else begin
                errors++;
                $display("[FAIL] match_line_o[%0d] expected %h actual %h",
                         p, exp_mask[p], match_line_o[p]);
            end
        end
    endtask

    // Search sees rows as they stand before its edge, then that edge's writes land
    task automatic predict_search();
        for (int p = 0; p < cam_pkg::CAM_READ_PORTS; p++) begin
            exp_mask[p] = '0;                           // Disabled port stays empty
            for (int r = 0; r < cam_pkg::CAM_DEPTH; r++) begin
                if (stage_re[p] && model_rows[r] == stage_rd[p]) begin
                    exp_mask[p][r] = 1'b1;
                end
            end
        end
        for (int p = 0; p < cam_pkg::CAM_WRITE_PORTS; p++) begin
            if (pend_we[p]) begin
                model_rows[pend_wa[p]] = pend_wd[p];    // Ascending, so port 1 wins a tie
            end
        end
        pend_we = stage_we;
        pend_wa = stage_wa;
        pend_wd = stage_wd;
    endtask

    task automatic run_cycle();
        @(posedge clk);
        write_en_i   <= stage_we;
        write_addr_i <= stage_wa;
        write_data_i <= stage_wd;
        read_en_i    <= stage_re;
        read_data_i  <= stage_rd;
        @(negedge clk);
        compare_masks();                                // Search sampled at the edge just passed
        predict_search();
        stage_we = '0;
        stage_re = '0;
    endtask

    task automatic model_expects(input bit ok, input string what);
        assert (ok) else begin
            errors++;
            $display("model prediction is wrong: %s", what);
        end
    endtask

    task automatic reset_state();
        set_search(0, 16'h0000);
        set_search(1, 16'h0000);
        run_cycle();
        model_expects(exp_mask[0] == '1 && exp_mask[1] == '1, "zero word should hit all rows");
        stage_rd = '0;
        run_cycle();                                    // Both ports disabled
        model_expects(exp_mask[0] == '0 && exp_mask[1] == '0, "disabled ports must be empty");
    endtask

    task automatic single_write_hit();
        set_write(0, 3'd3, 16'hBEEF);
        run_cycle();
        set_search(1, 16'hBEEF);                        // One edge after the write, still a miss
        run_cycle();
        model_expects(exp_mask[1] == '0, "write must not be visible one edge later");
        set_search(0, 16'hBEEF);
        set_search(1, 16'h1234);
        run_cycle();
        model_expects(exp_mask[0] == 8'b0000_1000, "stored word should hit row 3 only");
        model_expects(exp_mask[1] == '0, "other word should miss");
    endtask

    task automatic read_enable_gating();
        stage_rd[0] = 16'hBEEF;                         // Word present but enable clear
        set_search(1, 16'hBEEF);
        run_cycle();
        model_expects(exp_mask[0] == '0 && exp_mask[1] == 8'b0000_1000,
                      "gated port empty while enabled port hits row 3");
    endtask

    task automatic duplicate_words();
        set_write(0, 3'd0, 16'hCAFE);
        set_write(1, 3'd5, 16'hCAFE);
        run_cycle();
        set_write(0, 3'd6, 16'hCAFE);
        set_write(1, 3'd2, 16'h0042);
        run_cycle();
        run_cycle();
        set_search(0, 16'hCAFE);
        set_search(1, 16'h0042);
        run_cycle();
        model_expects(exp_mask[0] == 8'b0110_0001, "duplicate word should hit rows 0 5 6");
        model_expects(exp_mask[1] == 8'b0000_0100, "second word should hit row 2");
    endtask

    task automatic write_conflict();
        set_write(0, 3'd4, 16'h1111);
        set_write(1, 3'd4, 16'h2222);                   // Same row, port 1 must win
        run_cycle();
        run_cycle();
        set_search(0, 16'h2222);
        set_search(1, 16'h1111);
        run_cycle();
        model_expects(exp_mask[0][4] && !exp_mask[1][4], "row 4 should hold port 1 word");
    endtask

    task automatic random_traffic();
        repeat (RANDOM_CYCLES) begin
            for (int p = 0; p < cam_pkg::CAM_WRITE_PORTS; p++) begin
                stage_we[p] = 1'(rand_bits(1));
                stage_wa[p] = cam_pkg::cam_addr_t'(rand_bits(cam_pkg::CAM_ADDR_WIDTH));
                stage_wd[p] = cam_pkg::cam_word_t'(rand_bits(3));  // Small pool gives hits
            end
            for (int p = 0; p < cam_pkg::CAM_READ_PORTS; p++) begin
                stage_re[p] = 1'(rand_bits(1));
                stage_rd[p] = cam_pkg::cam_word_t'(rand_bits(3));
            end
            run_cycle();
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_i        = 1'b1;
        write_en_i   = '0;
        write_addr_i = '0;
        write_data_i = '0;
        read_en_i    = '0;
        read_data_i  = '0;
        stage_we     = '0;
        stage_wa     = '0;
        stage_wd     = '0;
        stage_re     = '0;
        stage_rd     = '0;
        pend_we      = '0;
        pend_wa      = '0;
        pend_wd      = '0;
        lfsr         = 32'hced283cf;
        errors       = 0;
        checks       = 0;
        for (int r = 0; r < cam_pkg::CAM_DEPTH; r++) begin
            model_rows[r] = '0;                         // Rows reset to zero
        end
        for (int p = 0; p < cam_pkg::CAM_READ_PORTS; p++) begin
            exp_mask[p] = '0;                           // First check sees the idle mask
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst_i <= 1'b0;
        reset_state();
        single_write_hit();
        read_enable_gating();
        duplicate_words();
        write_conflict();
        random_traffic();
        run_cycle();                                    // Checks the last search
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : cam_tb

//--- cam_top.f
hw/cam_pkg.sv
hw/cam_write_decoder.sv
hw/cam_storage_array.sv
hw/cam_match_resolver.sv
hw/cam_top.sv
bench/cam_tb.sv

//--- Makefile
# Verilator flow for the CAM project

VERILATOR  ?= verilator
TB_TOP     ?= cam_tb
RTL_TOP    ?= cam_top
FILELIST   ?= cam_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert

PASS_MSG   := PASS: all tests
SRCS       := $(wildcard hw/*.sv bench/*.sv)
SIM_BIN    := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
